/* dsp_datapath.f */
source/dsp_pkg.sv
source/dsp_cfg_regs.sv
source/sample_delay_line.sv
source/ffe_slicer.sv
source/residual_error_estimator.sv
source/error_energy_detector.sv
source/dsp_datapath_core.sv
dv/dsp_datapath_assert.sv
dv/dsp_datapath_tb.sv

/* Makefile */
TOP             ?= dsp_datapath_tb
FILELIST        ?= dsp_datapath.f
BUILD_DIR       ?= obj_dir
VERILATOR       ?= verilator
VERILATOR_FLAGS ?= --binary --timing --assert -Wno-fatal

.PHONY: sim clean

sim:
	$(VERILATOR) $(VERILATOR_FLAGS) --top-module $(TOP) -f $(FILELIST) \
		--Mdir $(BUILD_DIR) -o V$(TOP)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
		echo "$$out"; \
		echo "$$out" | grep -qx "Test OK"

clean:
	rm -rf $(BUILD_DIR)

/* dv/dsp_datapath_tb.sv */
`timescale 1ns/1ps

module dsp_datapath_tb;
    import dsp_pkg::*;

    localparam int clk_period    = 10;
    localparam int reset_cycles  = 8;
    localparam int stream_cycles = 20;
    localparam int write_cycles  = 16;
    localparam int flush_cycles  = 4;
    localparam int total_cycles  = reset_cycles + 1 + write_cycles + 8 * stream_cycles
                                   + flush_cycles;
    localparam int watchdog_ns   = (total_cycles + 50) * clk_period;

    logic      clk;
    logic      rst_n;
    code_t     adc_codes [channel_width-1:0];
    logic      cfg_wr;
    cfg_addr_t cfg_addr;
    cfg_data_t cfg_wdata;

    sym_t  stage1_symbols  [channel_width-1:0];
    est_t  stage1_est      [channel_width-1:0];
    sym_t  stage2_symbols  [channel_width-1:0];
    err_t  stage2_res_err  [channel_width-1:0];
    ener_t stage3_energy   [channel_width-1:0];
    logic  stage3_flags    [channel_width-1:0];
    sym_t  aligned_symbols [channel_width-1:0];
    err_t  aligned_res_err [channel_width-1:0];

    int          errors;
    logic [31:0] lfsr_state;

    // Reference model configuration
    int m_ffe_w [ffe_length];
    int m_ffe_shift;
    int m_levels [num_slice_levels];
    int m_chan [chan_length];
    int m_chan_shift;
    int m_thr;

    // Serial histories, sample index 4n + lane
    int code_q [$];
    int sym_q [$];
    int err_q [$];

    // Expected DUT outputs after the most recent clock edge
    int exp1_est [channel_width];
    int exp1_sym [channel_width];
    int exp1_code [channel_width];
    int exp2_sym [channel_width];
    int exp2_err [channel_width];
    int exp3_ener [channel_width];
    int exp3_flag [channel_width];
    int align_sym [channel_width];
    int align_err [channel_width];

    dsp_datapath_core uut (
        .clk               (clk),
        .rst_n_i           (rst_n),
        .adc_codes_i       (adc_codes),
        .cfg_wr_i          (cfg_wr),
        .cfg_addr_i        (cfg_addr),
        .cfg_wdata_i       (cfg_wdata),
        .stage1_symbols_o  (stage1_symbols),
        .stage1_est_o      (stage1_est),
        .stage2_symbols_o  (stage2_symbols),
        .stage2_res_err_o  (stage2_res_err),
        .stage3_energy_o   (stage3_energy),
        .stage3_flags_o    (stage3_flags),
        .aligned_symbols_o (aligned_symbols),
        .aligned_res_err_o (aligned_res_err)
    );

    initial begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    initial begin
        #(watchdog_ns);
        $display("Watchdog expired before the tests finished");
        $display("Test FAILED");
        $finish;
    end

    function automatic logic [31:0] galois_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    task automatic take_bits(input int n, output logic [31:0] bits);
        bits = '0;
        for (int b = 0; b < n; b++) begin
            lfsr_state = galois_next(lfsr_state);
            bits = {bits[30:0], lfsr_state[0]};
        end
    endtask

    function automatic int saturate(input int v, input int lo, input int hi);
        return (v > hi) ? hi : ((v < lo) ? lo : v);
    endfunction

    function automatic int slice_pam4(input int est);
        if (est < m_levels[0]) begin
            return -3;
        end else if (est < m_levels[1]) begin
            return -1;
        end else if (est < m_levels[2]) begin
            return 1;
        end
        return 3;
    endfunction

    task automatic check_symbol(input string name, input int lane, input sym_t exp,
                                input sym_t act);
        if (act !== exp) begin
            errors++;
            $display("Error at %0t: %s[%0d] expected %0d got %0d", $time, name, lane, exp, act);
        end
    endtask

    task automatic check_estimate(input string name, input int lane, input est_t exp,
                                  input est_t act);
        if (act !== exp) begin
            errors++;
            $display("Error at %0t: %s[%0d] expected %0d got %0d", $time, name, lane, exp, act);
        end
    endtask

    task automatic check_error(input string name, input int lane, input err_t exp,
                               input err_t act);
        if (act !== exp) begin
            errors++;
            $display("Error at %0t: %s[%0d] expected %0d got %0d", $time, name, lane, exp, act);
        end
    endtask

    task automatic check_energy(input string name, input int lane, input ener_t exp,
                                input ener_t act);
        if (act !== exp) begin
            errors++;
            $display("Error at %0t: %s[%0d] expected %0d got %0d", $time, name, lane, exp, act);
        end
    endtask

    task automatic check_flag(input string name, input int lane, input logic exp,
                              input logic act);
        if (act !== exp) begin
            errors++;
            $display("Error at %0t: %s[%0d] expected %b got %b", $time, name, lane, exp, act);
        end
    endtask

    task automatic compare_outputs;
        for (int i = 0; i < channel_width; i++) begin
            check_estimate("stage1_est_o", i, est_t'(exp1_est[i]), stage1_est[i]);
            check_symbol("stage1_symbols_o", i, sym_t'(exp1_sym[i]), stage1_symbols[i]);
            check_symbol("stage2_symbols_o", i, sym_t'(exp2_sym[i]), stage2_symbols[i]);
            check_error("stage2_res_err_o", i, err_t'(exp2_err[i]), stage2_res_err[i]);
            check_energy("stage3_energy_o", i, ener_t'(exp3_ener[i]), stage3_energy[i]);
            check_flag("stage3_flags_o", i, exp3_flag[i] != 0, stage3_flags[i]);
            check_symbol("aligned_symbols_o", i, sym_t'(align_sym[i]), aligned_symbols[i]);
            check_error("aligned_res_err_o", i, err_t'(align_err[i]), aligned_res_err[i]);
        end
    endtask

    task automatic model_reset;
        code_q.delete();
        sym_q.delete();
        err_q.delete();
        for (int i = 0; i < channel_width; i++) begin
            exp1_est[i]  = 0;
            exp1_sym[i]  = 0;
            exp1_code[i] = 0;
            exp2_sym[i]  = 0;
            exp2_err[i]  = 0;
            exp3_ener[i] = 0;
            exp3_flag[i] = 0;
            align_sym[i] = 0;
            align_err[i] = 0;
        end
        m_ffe_w      = '{1, 0, 0};
        m_ffe_shift  = 0;
        m_levels     = '{-2, 0, 2};
        m_chan       = '{1, 0, 0};
        m_chan_shift = 0;
        m_thr        = 1048575;
    endtask

    task automatic apply_write(input cfg_addr_t addr, input cfg_data_t data);
        case (addr)
            4'd0, 4'd1, 4'd2: m_ffe_w[addr] = int'($signed(data[7:0]));
            4'd3: m_ffe_shift = int'(data[3:0]);
            4'd4, 4'd5, 4'd6: m_levels[addr - 4] = int'($signed(data[9:0]));
            4'd7, 4'd8, 4'd9: m_chan[addr - 7] = int'($signed(data[7:0]));
            4'd10: m_chan_shift = int'(data[3:0]);
            4'd11: m_thr = int'(data);
            default: ;
        endcase
    endtask

    // Advances the model by the clock edge that captures the current inputs
    task automatic model_step;
        int base;
        int acc;
        int e_prev;
        base = err_q.size();
        for (int i = 0; i < channel_width; i++) begin
            err_q.push_back(exp2_err[i]);
        end
        for (int i = 0; i < channel_width; i++) begin
            e_prev = (base + i > 0) ? err_q[base + i - 1] : 0;
            exp3_ener[i] = err_q[base + i] * err_q[base + i] + e_prev * e_prev;
            exp3_flag[i] = (exp3_ener[i] > m_thr) ? 1 : 0;
            align_sym[i] = exp2_sym[i];
            align_err[i] = exp2_err[i];
        end
        base = sym_q.size();
        for (int i = 0; i < channel_width; i++) begin
            sym_q.push_back(exp1_sym[i]);
        end
        for (int i = 0; i < channel_width; i++) begin
            acc = 0;
            for (int j = 0; j < chan_length; j++) begin
                if (base + i - j >= 0) begin
                    acc += m_chan[j] * sym_q[base + i - j];
                end
            end
            acc = acc >>> m_chan_shift;
            exp2_err[i] = saturate(exp1_code[i] - acc, -512, 511);
            exp2_sym[i] = exp1_sym[i];
        end
        base = code_q.size();
        for (int i = 0; i < channel_width; i++) begin
            code_q.push_back(int'(adc_codes[i]));
        end
        for (int i = 0; i < channel_width; i++) begin
            acc = 0;
            for (int j = 0; j < ffe_length; j++) begin
                if (base + i - j >= 0) begin
                    acc += m_ffe_w[j] * code_q[base + i - j];
                end
            end
            acc = acc >>> m_ffe_shift;
            exp1_est[i]  = saturate(acc, -512, 511);
            exp1_sym[i]  = slice_pam4(exp1_est[i]);
            exp1_code[i] = code_q[base + i];
        end
        // A write counts from the next edge on
        if (cfg_wr) begin
            apply_write(cfg_addr, cfg_wdata);
        end
    endtask

    task automatic random_codes;
        logic [31:0] bits;
        for (int i = 0; i < channel_width; i++) begin
            take_bits(8, bits);
            adc_codes[i] = code_t'(bits[7:0]);
        end
    endtask

    task automatic drive_step(input logic wr, input cfg_addr_t addr, input cfg_data_t data);
        random_codes();
        cfg_wr    = wr;
        cfg_addr  = addr;
        cfg_wdata = data;
        model_step();
    endtask

    task automatic one_cycle(input logic wr, input cfg_addr_t addr, input cfg_data_t data);
        @(posedge clk);
        #1;
        compare_outputs();
        drive_step(wr, addr, data);
    endtask

    task automatic run_cycles(input int n);
        repeat (n) one_cycle(1'b0, '0, '0);
    endtask

    task automatic write_reg(input cfg_addr_t addr, input cfg_data_t data);
        one_cycle(1'b1, addr, data);
    endtask

    task automatic test_reset;
        model_reset();
        rst_n = 1'b0;
        repeat (reset_cycles) begin
            @(posedge clk);
            #1;
            compare_outputs();
            random_codes();
        end
        @(posedge clk);
        #1;
        rst_n = 1'b1;
        compare_outputs();
        drive_step(1'b0, '0, '0);
    endtask

    task automatic test_default_passthrough;
        run_cycles(2 * stream_cycles);
    endtask

    task automatic test_programmed_equalizer;
        write_reg(addr_ffe_weight_base, 16'd90);
        write_reg(cfg_addr_t'(addr_ffe_weight_base + 1), 16'hffc4);
        write_reg(cfg_addr_t'(addr_ffe_weight_base + 2), 16'd40);
        write_reg(addr_ffe_shift, 16'd4);
        write_reg(addr_slice_level_base, 16'hff9c);
        write_reg(cfg_addr_t'(addr_slice_level_base + 2), 16'd100);
        run_cycles(stream_cycles);
        // Shift change while codes keep flowing
        write_reg(addr_ffe_shift, 16'd6);
        run_cycles(stream_cycles);
    endtask

    task automatic test_residual_error;
        write_reg(addr_chan_tap_base, 16'd127);
        write_reg(cfg_addr_t'(addr_chan_tap_base + 1), 16'd100);
        write_reg(cfg_addr_t'(addr_chan_tap_base + 2), 16'hffa6);
        run_cycles(stream_cycles);
        write_reg(addr_chan_shift, 16'd1);
        run_cycles(stream_cycles);
    endtask

    task automatic test_energy_flags;
        write_reg(addr_chan_tap_base, 16'd30);
        write_reg(cfg_addr_t'(addr_chan_tap_base + 1), 16'd10);
        write_reg(cfg_addr_t'(addr_chan_tap_base + 2), 16'd0);
        write_reg(addr_chan_shift, 16'd0);
        write_reg(addr_ener_threshold, 16'd20000);
        run_cycles(2 * stream_cycles);
    endtask

    initial begin
        errors     = 0;
        lfsr_state = 32'h73d0;
        rst_n      = 1'b0;
        cfg_wr     = 1'b0;
        cfg_addr   = '0;
        cfg_wdata  = '0;
        for (int i = 0; i < channel_width; i++) begin
            adc_codes[i] = '0;
        end
        test_reset();
        test_default_passthrough();
        test_programmed_equalizer();
        test_residual_error();
        test_energy_flags();
        run_cycles(flush_cycles);
        $display("Checks finished with %0d errors", errors);
        if (errors == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

/* dv/dsp_datapath_assert.sv */
`timescale 1ns/1ps

module dsp_datapath_assert (
    input logic                clk,
    input logic                rst_n_i,
    input logic                flags_i           [dsp_pkg::channel_width-1:0],
    input dsp_pkg::sym_t       stage2_symbols_i  [dsp_pkg::channel_width-1:0],
    input dsp_pkg::err_t       stage2_res_err_i  [dsp_pkg::channel_width-1:0],
    input dsp_pkg::sym_t       aligned_symbols_i [dsp_pkg::channel_width-1:0],
    input dsp_pkg::err_t       aligned_res_err_i [dsp_pkg::channel_width-1:0]
);
    import dsp_pkg::*;

    for (genvar i = 0; i < channel_width; i++) begin : g_lane
        flag_known_a: assert property (
            @(posedge clk) disable iff (!rst_n_i) !$isunknown(flags_i[i])
        ) else $error("Stage 3 flag of lane %0d is unknown", i);

        // Alignment path is one cycle behind stage 2
        sym_align_a: assert property (
            @(posedge clk) disable iff (!rst_n_i)
            aligned_symbols_i[i] == $past(stage2_symbols_i[i])
        ) else $error("Aligned symbol of lane %0d is out of step", i);

        err_align_a: assert property (
            @(posedge clk) disable iff (!rst_n_i)
            aligned_res_err_i[i] == $past(stage2_res_err_i[i])
        ) else $error("Aligned error of lane %0d is out of step", i);
    end

endmodule

bind dsp_datapath_core dsp_datapath_assert assert_i (
    .clk               (clk),
    .rst_n_i           (rst_n_i),
    .flags_i           (stage3_flags_o),
    .stage2_symbols_i  (stage2_symbols_o),
    .stage2_res_err_i  (stage2_res_err_o),
    .aligned_symbols_i (aligned_symbols_o),
    .aligned_res_err_i (aligned_res_err_o)
);

/* source/dsp_datapath_core.sv */
`timescale 1ns/1ps

module dsp_datapath_core (
    input  logic                clk,
    input  logic                rst_n_i,
    input  dsp_pkg::code_t      adc_codes_i       [dsp_pkg::channel_width-1:0],
    input  logic                cfg_wr_i,
    input  dsp_pkg::cfg_addr_t  cfg_addr_i,
    input  dsp_pkg::cfg_data_t  cfg_wdata_i,
    output dsp_pkg::sym_t       stage1_symbols_o  [dsp_pkg::channel_width-1:0],
    output dsp_pkg::est_t       stage1_est_o      [dsp_pkg::channel_width-1:0],
    output dsp_pkg::sym_t       stage2_symbols_o  [dsp_pkg::channel_width-1:0],
    output dsp_pkg::err_t       stage2_res_err_o  [dsp_pkg::channel_width-1:0],
    output dsp_pkg::ener_t      stage3_energy_o   [dsp_pkg::channel_width-1:0],
    output logic                stage3_flags_o    [dsp_pkg::channel_width-1:0],
    output dsp_pkg::sym_t       aligned_symbols_o [dsp_pkg::channel_width-1:0],
    output dsp_pkg::err_t       aligned_res_err_o [dsp_pkg::channel_width-1:0]
);
    import dsp_pkg::*;

    weight_t ffe_weights    [ffe_length-1:0];
    shift_t  ffe_shift;
    est_t    slice_levels   [num_slice_levels-1:0];
    weight_t chan_taps      [chan_length-1:0];
    shift_t  chan_shift;
    ener_t   ener_threshold;
    code_t   stage1_codes   [channel_width-1:0];

    dsp_cfg_regs cfg_regs_i (
        .clk              (clk),
        .rst_n_i          (rst_n_i),
        .cfg_wr_i         (cfg_wr_i),
        .cfg_addr_i       (cfg_addr_i),
        .cfg_wdata_i      (cfg_wdata_i),
        .ffe_weights_o    (ffe_weights),
        .ffe_shift_o      (ffe_shift),
        .slice_levels_o   (slice_levels),
        .chan_taps_o      (chan_taps),
        .chan_shift_o     (chan_shift),
        .ener_threshold_o (ener_threshold)
    );

    ffe_slicer ffe_stage1_i (
        .clk            (clk),
        .rst_n_i        (rst_n_i),
        .codes_i        (adc_codes_i),
        .ffe_weights_i  (ffe_weights),
        .ffe_shift_i    (ffe_shift),
        .slice_levels_i (slice_levels),
        .est_o          (stage1_est_o),
        .symbols_o      (stage1_symbols_o),
        .codes_o        (stage1_codes)
    );

    residual_error_estimator res_err_stage2_i (
        .clk          (clk),
        .rst_n_i      (rst_n_i),
        .symbols_i    (stage1_symbols_o),
        .codes_i      (stage1_codes),
        .chan_taps_i  (chan_taps),
        .chan_shift_i (chan_shift),
        .symbols_o    (stage2_symbols_o),
        .res_err_o    (stage2_res_err_o)
    );

    error_energy_detector ener_stage3_i (
        .clk              (clk),
        .rst_n_i          (rst_n_i),
        .res_err_i        (stage2_res_err_o),
        .ener_threshold_i (ener_threshold),
        .energy_o         (stage3_energy_o),
        .flags_o          (stage3_flags_o)
    );

    // Stage 2 outputs delayed to line up with the stage 3 flags
    sample_delay_line #(
        .payload_t (sym_t),
        .depth     (align_depth)
    ) sym_align_i (
        .clk     (clk),
        .rst_n_i (rst_n_i),
        .data_i  (stage2_symbols_o),
        .data_o  (aligned_symbols_o)
    );

    sample_delay_line #(
        .payload_t (err_t),
        .depth     (align_depth)
    ) err_align_i (
        .clk     (clk),
        .rst_n_i (rst_n_i),
        .data_i  (stage2_res_err_o),
        .data_o  (aligned_res_err_o)
    );

endmodule

/* source/error_energy_detector.sv */
`timescale 1ns/1ps

module error_energy_detector (
    input  logic            clk,
    input  logic            rst_n_i,
    input  dsp_pkg::err_t   res_err_i        [dsp_pkg::channel_width-1:0],
    input  dsp_pkg::ener_t  ener_threshold_i,
    output dsp_pkg::ener_t  energy_o         [dsp_pkg::channel_width-1:0],
    output logic            flags_o          [dsp_pkg::channel_width-1:0]
);
    import dsp_pkg::*;

    // Lane 3 error of the previous cycle
    err_t hist_q;
    err_t window [channel_width:0];
    logic signed [2*$bits(err_t)-1:0] sq [channel_width:0];
    ener_t ener_d [channel_width-1:0];

    always_comb begin
        window[0] = hist_q;
        for (int i = 0; i < channel_width; i++) begin
            window[i + 1] = res_err_i[i];
        end
        for (int i = 0; i <= channel_width; i++) begin
            sq[i] = window[i] * window[i];
        end
        // Two squares of 2**18 at most, so the sum fits unsigned
        for (int i = 0; i < channel_width; i++) begin
            ener_d[i] = ener_t'(sq[i]) + ener_t'(sq[i + 1]);
        end
    end

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            hist_q <= '0;
            for (int i = 0; i < channel_width; i++) begin
                energy_o[i] <= '0;
                flags_o[i]  <= 1'b0;
            end
        end else begin
            hist_q <= res_err_i[channel_width-1];
            for (int i = 0; i < channel_width; i++) begin
                energy_o[i] <= ener_d[i];
                flags_o[i]  <= ener_d[i] > ener_threshold_i;
            end
        end
    end

endmodule

/* source/residual_error_estimator.sv */
`timescale 1ns/1ps

module residual_error_estimator (
    input  logic              clk,
    input  logic              rst_n_i,
    input  dsp_pkg::sym_t     symbols_i    [dsp_pkg::channel_width-1:0],
    input  dsp_pkg::code_t    codes_i      [dsp_pkg::channel_width-1:0],
    input  dsp_pkg::weight_t  chan_taps_i  [dsp_pkg::chan_length-1:0],
    input  dsp_pkg::shift_t   chan_shift_i,
    output dsp_pkg::sym_t     symbols_o    [dsp_pkg::channel_width-1:0],
    output dsp_pkg::err_t     res_err_o    [dsp_pkg::channel_width-1:0]
);
    import dsp_pkg::*;

    sym_t hist_q [chan_length-2:0];
    sym_t window [channel_width+chan_length-2:0];
    logic signed [chan_acc_width-1:0] recon [channel_width-1:0];
    // One bit wider than the reconstruction for the subtraction
    logic signed [chan_acc_width:0]   diff  [channel_width-1:0];
    err_t err_d [channel_width-1:0];

    always_comb begin
        for (int h = 0; h < chan_length - 1; h++) begin
            window[h] = hist_q[h];
        end
        for (int i = 0; i < channel_width; i++) begin
            window[i + chan_length - 1] = symbols_i[i];
        end
        for (int i = 0; i < channel_width; i++) begin
            recon[i] = '0;
            for (int j = 0; j < chan_length; j++) begin
                recon[i] = recon[i] + chan_taps_i[j] * window[i + chan_length - 1 - j];
            end
            recon[i] = recon[i] >>> chan_shift_i;
            diff[i]  = codes_i[i] - recon[i];
            if (diff[i] > err_max) begin
                err_d[i] = err_max;
            end else if (diff[i] < err_min) begin
                err_d[i] = err_min;
            end else begin
                err_d[i] = err_t'(diff[i]);
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            for (int h = 0; h < chan_length - 1; h++) begin
                hist_q[h] <= '0;
            end
            for (int i = 0; i < channel_width; i++) begin
                symbols_o[i] <= '0;
                res_err_o[i] <= '0;
            end
        end else begin
            for (int h = 0; h < chan_length - 1; h++) begin
                hist_q[h] <= symbols_i[channel_width - chan_length + 1 + h];
            end
            for (int i = 0; i < channel_width; i++) begin
                symbols_o[i] <= symbols_i[i];
                res_err_o[i] <= err_d[i];
            end
        end
    end

endmodule

/* source/ffe_slicer.sv */
`timescale 1ns/1ps

module ffe_slicer (
    input  logic              clk,
    input  logic              rst_n_i,
    input  dsp_pkg::code_t    codes_i        [dsp_pkg::channel_width-1:0],
    input  dsp_pkg::weight_t  ffe_weights_i  [dsp_pkg::ffe_length-1:0],
    input  dsp_pkg::shift_t   ffe_shift_i,
    input  dsp_pkg::est_t     slice_levels_i [dsp_pkg::num_slice_levels-1:0],
    output dsp_pkg::est_t     est_o          [dsp_pkg::channel_width-1:0],
    output dsp_pkg::sym_t     symbols_o      [dsp_pkg::channel_width-1:0],
    output dsp_pkg::code_t    codes_o        [dsp_pkg::channel_width-1:0]
);
    import dsp_pkg::*;

    // Last lanes of the previous cycle, oldest first
    code_t hist_q [ffe_length-2:0];
    // Serial window with history in front of the current lanes
    code_t window [channel_width+ffe_length-2:0];
    logic signed [ffe_acc_width-1:0] acc [channel_width-1:0];
    est_t est_d [channel_width-1:0];
    sym_t sym_d [channel_width-1:0];

    always_comb begin
        for (int h = 0; h < ffe_length - 1; h++) begin
            window[h] = hist_q[h];
        end
        for (int i = 0; i < channel_width; i++) begin
            window[i + ffe_length - 1] = codes_i[i];
        end
        for (int i = 0; i < channel_width; i++) begin
            acc[i] = '0;
            for (int j = 0; j < ffe_length; j++) begin
                acc[i] = acc[i] + ffe_weights_i[j] * window[i + ffe_length - 1 - j];
            end
            acc[i] = acc[i] >>> ffe_shift_i;
            if (acc[i] > est_max) begin
                est_d[i] = est_max;
            end else if (acc[i] < est_min) begin
                est_d[i] = est_min;
            end else begin
                est_d[i] = est_t'(acc[i]);
            end
            // PAM4 decision against low, mid and high levels
            if (est_d[i] < slice_levels_i[0]) begin
                sym_d[i] = sym_m3;
            end else if (est_d[i] < slice_levels_i[1]) begin
                sym_d[i] = sym_m1;
            end else if (est_d[i] < slice_levels_i[2]) begin
                sym_d[i] = sym_p1;
            end else begin
                sym_d[i] = sym_p3;
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            for (int h = 0; h < ffe_length - 1; h++) begin
                hist_q[h] <= '0;
            end
            for (int i = 0; i < channel_width; i++) begin
                est_o[i]     <= '0;
                symbols_o[i] <= '0;
                codes_o[i]   <= '0;
            end
        end else begin
            for (int h = 0; h < ffe_length - 1; h++) begin
                hist_q[h] <= codes_i[channel_width - ffe_length + 1 + h];
            end
            for (int i = 0; i < channel_width; i++) begin
                est_o[i]     <= est_d[i];
                symbols_o[i] <= sym_d[i];
                codes_o[i]   <= codes_i[i];
            end
        end
    end

endmodule

/* source/sample_delay_line.sv */
`timescale 1ns/1ps

module sample_delay_line #(
    parameter type payload_t = logic,
    parameter int  depth     = 1
) (
    input  logic     clk,
    input  logic     rst_n_i,
    input  payload_t data_i [dsp_pkg::channel_width-1:0],
    output payload_t data_o [dsp_pkg::channel_width-1:0]
);
    import dsp_pkg::*;

    payload_t pipe_q [channel_width-1:0][depth-1:0];

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            for (int i = 0; i < channel_width; i++) begin
                for (int d = 0; d < depth; d++) begin
                    pipe_q[i][d] <= '0;
                end
            end
        end else begin
            for (int i = 0; i < channel_width; i++) begin
                pipe_q[i][0] <= data_i[i];
                for (int d = 1; d < depth; d++) begin
                    pipe_q[i][d] <= pipe_q[i][d-1];
                end
            end
        end
    end

    always_comb begin
        for (int i = 0; i < channel_width; i++) begin
            data_o[i] = pipe_q[i][depth-1];
        end
    end

endmodule

/* source/dsp_cfg_regs.sv */
`timescale 1ns/1ps

module dsp_cfg_regs (
    input  logic                 clk,
    input  logic                 rst_n_i,
    input  logic                 cfg_wr_i,
    input  dsp_pkg::cfg_addr_t   cfg_addr_i,
    input  dsp_pkg::cfg_data_t   cfg_wdata_i,
    output dsp_pkg::weight_t     ffe_weights_o    [dsp_pkg::ffe_length-1:0],
    output dsp_pkg::shift_t      ffe_shift_o,
    output dsp_pkg::est_t        slice_levels_o   [dsp_pkg::num_slice_levels-1:0],
    output dsp_pkg::weight_t     chan_taps_o      [dsp_pkg::chan_length-1:0],
    output dsp_pkg::shift_t      chan_shift_o,
    output dsp_pkg::ener_t       ener_threshold_o
);
    import dsp_pkg::*;

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            for (int j = 0; j < ffe_length; j++) begin
                ffe_weights_o[j] <= ffe_weights_rst[j];
            end
            for (int j = 0; j < num_slice_levels; j++) begin
                slice_levels_o[j] <= slice_levels_rst[j];
            end
            for (int j = 0; j < chan_length; j++) begin
                chan_taps_o[j] <= chan_taps_rst[j];
            end
            ffe_shift_o      <= ffe_shift_rst;
            chan_shift_o     <= chan_shift_rst;
            ener_threshold_o <= ener_threshold_rst;
        end else if (cfg_wr_i) begin
            // Each register keeps only the low bits it needs
            for (int j = 0; j < ffe_length; j++) begin
                if (cfg_addr_i == cfg_addr_t'(addr_ffe_weight_base + j)) begin
                    ffe_weights_o[j] <= weight_t'(cfg_wdata_i[$bits(weight_t)-1:0]);
                end
            end
            for (int j = 0; j < num_slice_levels; j++) begin
                if (cfg_addr_i == cfg_addr_t'(addr_slice_level_base + j)) begin
                    slice_levels_o[j] <= est_t'(cfg_wdata_i[$bits(est_t)-1:0]);
                end
            end
            for (int j = 0; j < chan_length; j++) begin
                if (cfg_addr_i == cfg_addr_t'(addr_chan_tap_base + j)) begin
                    chan_taps_o[j] <= weight_t'(cfg_wdata_i[$bits(weight_t)-1:0]);
                end
            end
            if (cfg_addr_i == addr_ffe_shift) begin
                ffe_shift_o <= cfg_wdata_i[$bits(shift_t)-1:0];
            end
            if (cfg_addr_i == addr_chan_shift) begin
                chan_shift_o <= cfg_wdata_i[$bits(shift_t)-1:0];
            end
            if (cfg_addr_i == addr_ener_threshold) begin
                ener_threshold_o <= ener_t'(cfg_wdata_i);
            end
        end
    end

endmodule

/* source/dsp_pkg.sv */
package dsp_pkg;

    // Lane and tap counts
    localparam int channel_width    = 4;
    localparam int ffe_length       = 3;
    localparam int chan_length      = 3;
    localparam int num_slice_levels = 3;

    typedef logic signed [7:0]  code_t;
    typedef logic signed [7:0]  weight_t;
    typedef logic        [3:0]  shift_t;
    typedef logic signed [9:0]  est_t;
    typedef logic signed [2:0]  sym_t;
    typedef logic signed [9:0]  err_t;
    typedef logic        [19:0] ener_t;

    typedef logic [3:0]  cfg_addr_t;
    typedef logic [15:0] cfg_data_t;

    // Accumulator widths before the shift
    localparam int ffe_acc_width  = $bits(code_t) + $bits(weight_t) + $clog2(ffe_length);
    localparam int chan_acc_width = $bits(sym_t) + $bits(weight_t) + $clog2(chan_length);

    localparam est_t est_max = 10'sd511;
    localparam est_t est_min = -10'sd512;
    localparam err_t err_max = 10'sd511;
    localparam err_t err_min = -10'sd512;

    // PAM4 levels
    localparam sym_t sym_m3 = -3'sd3;
    localparam sym_t sym_m1 = -3'sd1;
    localparam sym_t sym_p1 = 3'sd1;
    localparam sym_t sym_p3 = 3'sd3;

    // Register map
    localparam cfg_addr_t addr_ffe_weight_base  = 4'd0;
    localparam cfg_addr_t addr_ffe_shift        = 4'd3;
    localparam cfg_addr_t addr_slice_level_base = 4'd4;
    localparam cfg_addr_t addr_chan_tap_base    = 4'd7;
    localparam cfg_addr_t addr_chan_shift       = 4'd10;
    localparam cfg_addr_t addr_ener_threshold   = 4'd11;

    // Reset values, index 0 first
    localparam weight_t ffe_weights_rst [ffe_length]        = '{8'sd1, 8'sd0, 8'sd0};
    localparam shift_t  ffe_shift_rst                       = 4'd0;
    localparam est_t    slice_levels_rst [num_slice_levels] = '{-10'sd2, 10'sd0, 10'sd2};
    localparam weight_t chan_taps_rst [chan_length]         = '{8'sd1, 8'sd0, 8'sd0};
    localparam shift_t  chan_shift_rst                      = 4'd0;
    localparam ener_t   ener_threshold_rst                  = '1;

    localparam int stage3_latency = 3;
    // Stage 2 outputs leave two cycles after the codes
    localparam int align_depth    = stage3_latency - 2;

endpackage
